// ==== design/rv32_pkg.sv ====
// shared widths, instruction class and ALU enums, major opcodes and default reset PC
package rv32_pkg;

    parameter int XLEN       = 32;          // data and address width
    parameter int REG_ADDR_W = 5;           // register index width
    parameter int NUM_REGS   = 32;          // x0..x31, x0 reads as zero

    parameter logic [XLEN-1:0] PC_RESET_DEFAULT = 32'h0000_0000; // first fetch address

    // instruction classes the core understands
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,                    // bubble or unsupported word
        OP_RTYPE = 3'd1,                    // register-register
        OP_ITYPE = 3'd2,                    // register-immediate
        OP_LUI   = 3'd3,                    // load upper immediate
        OP_AUIPC = 3'd4                     // pc plus upper immediate
    } opcode_e;

    // ALU operations, arithmetic and logic first, shifts last
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,                        // signed compare
        SLTU = 4'd3,                        // unsigned compare
        XOR  = 4'd4,
        OR   = 4'd5,
        AND  = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,                        // logical right
        SRA  = 4'd9                         // arithmetic right
    } alu_op_e;

    // major opcodes, inst[6:0]
    parameter logic [6:0] OPC_OP     = 7'b0110011; // R-type ALU
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011; // I-type ALU
    parameter logic [6:0] OPC_LUI    = 7'b0110111;
    parameter logic [6:0] OPC_AUIPC  = 7'b0010111;

    // funct7 patterns of the base ALU group
    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA/SRAI

endpackage

// ==== design/rv32_pipe_if.sv ====
// pipeline interfaces: decode to execute, execute to result, register file read port
interface dec_exe_if;
    logic                                valid;    // one decoded instruction this cycle
    rv32_pkg::opcode_e                   opcode;
    rv32_pkg::alu_op_e                   alu_op;
    logic [rv32_pkg::REG_ADDR_W-1:0]     rs1_addr;
    logic [rv32_pkg::REG_ADDR_W-1:0]     rs2_addr;
    logic [rv32_pkg::REG_ADDR_W-1:0]     rd_addr;
    logic [rv32_pkg::XLEN-1:0]           imm;      // sign-extended I or U immediate
    logic [rv32_pkg::XLEN-1:0]           pc;       // fetch address, for AUIPC

    modport src (output valid, opcode, alu_op, rs1_addr, rs2_addr, rd_addr, imm, pc);
    modport dst (input  valid, opcode, alu_op, rs1_addr, rs2_addr, rd_addr, imm, pc);
endinterface

interface exe_res_if;
    logic                                valid;    // only for writes to a nonzero rd
    logic [rv32_pkg::REG_ADDR_W-1:0]     rd_addr;
    logic [rv32_pkg::XLEN-1:0]           rd_data;

    modport src (output valid, rd_addr, rd_data);
    modport dst (input  valid, rd_addr, rd_data);
endinterface

interface reg_read_if;
    logic [rv32_pkg::REG_ADDR_W-1:0]     rs1_addr;
    logic [rv32_pkg::REG_ADDR_W-1:0]     rs2_addr;
    logic [rv32_pkg::XLEN-1:0]           rs1_data; // combinational from the file
    logic [rv32_pkg::XLEN-1:0]           rs2_data;

    modport req (output rs1_addr, rs2_addr, input  rs1_data, rs2_data);
    modport rsp (input  rs1_addr, rs2_addr, output rs1_data, rs2_data);
endinterface

// ==== design/rv32_decode.sv ====
// decode stage: program counter, fetch strobe and instruction decode register
module rv32_decode #(
    parameter logic [rv32_pkg::XLEN-1:0] PC_RESET = rv32_pkg::PC_RESET_DEFAULT
) (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic [rv32_pkg::XLEN-1:0] i_inst,     // valid while i_ack_inst is high
    input  logic                      i_ack_inst,
    output logic [rv32_pkg::XLEN-1:0] o_iaddr,
    output logic                      o_stb_inst,
    dec_exe_if.src                    dec
);
    localparam logic [rv32_pkg::XLEN-1:0] PC_STEP = 4; // one word per instruction

    logic [rv32_pkg::XLEN-1:0] pc_q;
    logic                      accept;                  // instruction taken this edge
    logic [6:0]                opc;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic                      r_legal;
    logic                      i_legal;
    rv32_pkg::opcode_e         opcode_d;
    rv32_pkg::alu_op_e         alu_op_d;
    logic [rv32_pkg::XLEN-1:0] imm_d;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic rv32_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_of = alt ? rv32_pkg::SUB : rv32_pkg::ADD;
            3'b001:  alu_of = rv32_pkg::SLL;
            3'b010:  alu_of = rv32_pkg::SLT;
            3'b011:  alu_of = rv32_pkg::SLTU;
            3'b100:  alu_of = rv32_pkg::XOR;
            3'b101:  alu_of = alt ? rv32_pkg::SRA : rv32_pkg::SRL;
            3'b110:  alu_of = rv32_pkg::OR;
            default: alu_of = rv32_pkg::AND;
        endcase
    endfunction

    assign accept  = o_stb_inst & i_ack_inst;
    assign o_iaddr = pc_q;
    assign opc     = i_inst[6:0];
    assign funct3  = i_inst[14:12];
    assign funct7  = i_inst[31:25];
    // only ADD/SUB and SRL/SRA have an alternate encoding
    assign r_legal = (funct7 == rv32_pkg::F7_BASE) ||
                     (funct7 == rv32_pkg::F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
    // shift immediates carry funct7 in imm[11:5]
    assign i_legal = (funct3 == 3'b001) ? (funct7 == rv32_pkg::F7_BASE) :
                     (funct3 == 3'b101) ? (funct7 == rv32_pkg::F7_BASE ||
                                           funct7 == rv32_pkg::F7_ALT) : 1'b1;

    always_comb begin
        opcode_d = rv32_pkg::OP_NONE;                     // anything unlisted is a bubble
        alu_op_d = rv32_pkg::ADD;
        imm_d    = {{(rv32_pkg::XLEN-12){i_inst[31]}}, i_inst[31:20]}; // I-type
        case (opc)
            rv32_pkg::OPC_OP: begin
                if (r_legal) begin
                    opcode_d = rv32_pkg::OP_RTYPE;
                    alu_op_d = alu_of(funct3, funct7[5]);
                end
            end
            rv32_pkg::OPC_OP_IMM: begin
                if (i_legal) begin
                    opcode_d = rv32_pkg::OP_ITYPE;
                    alu_op_d = alu_of(funct3, funct3 == 3'b101 && funct7[5]); // no SUBI
                end
            end
            rv32_pkg::OPC_LUI: begin
                opcode_d = rv32_pkg::OP_LUI;
                imm_d    = {i_inst[31:12], 12'b0};        // U-type
            end
            rv32_pkg::OPC_AUIPC: begin
                opcode_d = rv32_pkg::OP_AUIPC;
                imm_d    = {i_inst[31:12], 12'b0};
            end
            default: opcode_d = rv32_pkg::OP_NONE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q       <= PC_RESET;
            o_stb_inst <= 1'b0;
            dec.valid  <= 1'b0;
        end else begin
            o_stb_inst <= 1'b1;                           // fetch runs from the first edge on
            dec.valid  <= accept && (opcode_d != rv32_pkg::OP_NONE);
            if (accept) pc_q <= pc_q + PC_STEP;           // hold on a missing ack
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            dec.opcode   <= opcode_d;
            dec.alu_op   <= alu_op_d;
            dec.rs1_addr <= i_inst[19:15];
            dec.rs2_addr <= i_inst[24:20];
            dec.rd_addr  <= i_inst[11:7];
            dec.imm      <= imm_d;
            dec.pc       <= pc_q;                         // address this word came from
        end
    end

endmodule

// ==== design/rv32_execute.sv ====
// execute stage: operand forwarding, ALU and execute result register
module rv32_execute (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    dec_exe_if.dst                          dec,
    reg_read_if.req                         rd_port,
    exe_res_if.src                          res,
    input  logic [rv32_pkg::REG_ADDR_W-1:0] i_res_rd_addr, // retire copy, two older
    input  logic [rv32_pkg::XLEN-1:0]       i_res_rd_data,
    input  logic                            i_res_wr
);
    logic [rv32_pkg::XLEN-1:0] rs1_val;           // forwarded operands
    logic [rv32_pkg::XLEN-1:0] rs2_val;
    logic [rv32_pkg::XLEN-1:0] op_a;
    logic [rv32_pkg::XLEN-1:0] op_b;
    logic [4:0]                shamt;
    logic [rv32_pkg::XLEN-1:0] alu_y;

    // newest value of a source register
    function automatic logic [rv32_pkg::XLEN-1:0] fwd(
        input logic [rv32_pkg::REG_ADDR_W-1:0] addr,
        input logic [rv32_pkg::XLEN-1:0]       file_data
    );
        if (addr == '0)
            fwd = '0;                                          // x0
        else if (res.valid && res.rd_addr == addr)
            fwd = res.rd_data;                                 // one older, own register
        else if (i_res_wr && i_res_rd_addr == addr)
            fwd = i_res_rd_data;                               // two older, retire register
        else
            fwd = file_data;                                   // committed state
    endfunction

    assign rd_port.rs1_addr = dec.rs1_addr;       // file is read in this cycle
    assign rd_port.rs2_addr = dec.rs2_addr;
    assign rs1_val = fwd(dec.rs1_addr, rd_port.rs1_data);
    assign rs2_val = fwd(dec.rs2_addr, rd_port.rs2_data);

    assign op_a  = (dec.opcode == rv32_pkg::OP_AUIPC) ? dec.pc : rs1_val;
    assign op_b  = (dec.opcode == rv32_pkg::OP_RTYPE) ? rs2_val : dec.imm;
    assign shamt = op_b[4:0];                     // shifts use the low 5 bits only

    always_comb begin
        case (dec.alu_op)
            rv32_pkg::ADD:  alu_y = op_a + op_b;
            rv32_pkg::SUB:  alu_y = op_a - op_b;
            rv32_pkg::SLT:  alu_y = {{(rv32_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv32_pkg::SLTU: alu_y = {{(rv32_pkg::XLEN-1){1'b0}}, op_a < op_b};
            rv32_pkg::XOR:  alu_y = op_a ^ op_b;
            rv32_pkg::OR:   alu_y = op_a | op_b;
            rv32_pkg::AND:  alu_y = op_a & op_b;
            rv32_pkg::SLL:  alu_y = op_a << shamt;
            rv32_pkg::SRL:  alu_y = op_a >> shamt;
            rv32_pkg::SRA:  alu_y = $unsigned($signed(op_a) >>> shamt);
            default:        alu_y = op_a + op_b;
        endcase
        if (dec.opcode == rv32_pkg::OP_LUI) alu_y = dec.imm; // upper immediate passes through
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= dec.valid && (dec.rd_addr != '0); // rd zero writes nothing
        end
    end

    always_ff @(posedge i_clk) begin
        if (dec.valid) begin
            res.rd_addr <= dec.rd_addr;
            res.rd_data <= alu_y;
        end
    end

endmodule

// ==== design/rv32_result.sv ====
// result stage: base register file and retire write outputs
module rv32_result (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    exe_res_if.dst                          res,
    reg_read_if.rsp                         rd_port,
    output logic                            o_rd_wr,     // one pulse per write
    output logic [rv32_pkg::REG_ADDR_W-1:0] o_rd_addr,
    output logic [rv32_pkg::XLEN-1:0]       o_rd_data
);
    // x1..x31 only, x0 has no storage
    logic [rv32_pkg::XLEN-1:0] regs [1:rv32_pkg::NUM_REGS-1];

    function automatic logic [rv32_pkg::XLEN-1:0] rd_reg(
        input logic [rv32_pkg::REG_ADDR_W-1:0] addr
    );
        if (addr == '0)
            rd_reg = '0;
        else
            rd_reg = regs[addr];
    endfunction

    assign rd_port.rs1_data = rd_reg(rd_port.rs1_addr);
    assign rd_port.rs2_data = rd_reg(rd_port.rs2_addr);

    always_ff @(posedge i_clk) begin
        if (res.valid) regs[res.rd_addr] <= res.rd_data; // valid implies rd nonzero
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rd_wr <= 1'b0;
        end else begin
            o_rd_wr <= res.valid;                 // same edge as the file write
        end
    end

    // also the two-older forwarding source for execute
    always_ff @(posedge i_clk) begin
        if (res.valid) begin
            o_rd_addr <= res.rd_addr;
            o_rd_data <= res.rd_data;
        end
    end

endmodule

// ==== design/rv32_core.sv ====
// top level: three-stage RV32I integer core with instruction fetch and retire ports
module rv32_core #(
    parameter logic [rv32_pkg::XLEN-1:0] PC_RESET = rv32_pkg::PC_RESET_DEFAULT
) (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic [rv32_pkg::XLEN-1:0]       i_inst,      // instruction word at o_iaddr
    input  logic                            i_ack_inst,  // word valid this cycle
    output logic [rv32_pkg::XLEN-1:0]       o_iaddr,
    output logic                            o_stb_inst,
    output logic                            o_rd_wr,     // retire strobe
    output logic [rv32_pkg::REG_ADDR_W-1:0] o_rd_addr,
    output logic [rv32_pkg::XLEN-1:0]       o_rd_data
);
    dec_exe_if  u_dec_exe ();                     // decode -> execute
    exe_res_if  u_exe_res ();                     // execute -> result
    reg_read_if u_reg_rd ();                      // execute <-> register file

    rv32_decode #(
        .PC_RESET   (PC_RESET)
    ) u_decode (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_inst     (i_inst),
        .i_ack_inst (i_ack_inst),
        .o_iaddr    (o_iaddr),
        .o_stb_inst (o_stb_inst),
        .dec        (u_dec_exe.src)
    );

    rv32_execute u_execute (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .dec           (u_dec_exe.dst),
        .rd_port       (u_reg_rd.req),
        .res           (u_exe_res.src),
        .i_res_rd_addr (o_rd_addr),               // retire registers double as forwarding
        .i_res_rd_data (o_rd_data),
        .i_res_wr      (o_rd_wr)
    );

    rv32_result u_result (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .res       (u_exe_res.dst),
        .rd_port   (u_reg_rd.rsp),
        .o_rd_wr   (o_rd_wr),
        .o_rd_addr (o_rd_addr),
        .o_rd_data (o_rd_data)
    );

endmodule

// ==== verification/rv32_core_chk.sv ====
// bound checker: retire address, fetch address stepping and quiet retire during reset
module rv32_core_chk (
    input logic                            i_clk,
    input logic                            i_arst_n,
    input logic                            i_ack_inst,
    input logic                            o_stb_inst,
    input logic                            o_rd_wr,
    input logic [rv32_pkg::XLEN-1:0]       o_iaddr,
    input logic [rv32_pkg::REG_ADDR_W-1:0] o_rd_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    a_rd_nonzero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_rd_wr |-> (o_rd_addr != '0))                         // x0 is never written
        else $error("retire write with rd zero");

    a_pc_step: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (o_stb_inst && i_ack_inst) |=> (o_iaddr == $past(o_iaddr) + 32'd4))
        else $error("fetch address did not advance by 4 after an accepted word");

    a_pc_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(o_stb_inst && i_ack_inst) |=> $stable(o_iaddr))     // bubble holds the PC
        else $error("fetch address moved without an accepted word");

    a_reset_quiet: assert property (@(posedge i_clk) !i_arst_n |-> !o_rd_wr)
        else $error("retire write during reset");

endmodule

// ==== verification/rv32_core_tb.sv ====
// testbench for rv32_core: clock, reset, file-driven program, fetch and retire checks, report
module rv32_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_INST      = 28;                  // instructions in the stim file
    localparam int          CYCLE_LIMIT = 4 * (2 * N_INST) + 50; // two runs of the program
    localparam logic [31:0] PC_START    = 32'h100;
    localparam logic [15:0] LFSR_SEED   = 16'd51037;

    logic                            i_clk = 1'b0;
    logic                            i_arst_n;
    logic [rv32_pkg::XLEN-1:0]       i_inst;
    logic                            i_ack_inst;
    logic [rv32_pkg::XLEN-1:0]       o_iaddr;
    logic                            o_stb_inst;
    logic                            o_rd_wr;
    logic [rv32_pkg::REG_ADDR_W-1:0] o_rd_addr;
    logic [rv32_pkg::XLEN-1:0]       o_rd_data;

    logic [31:0] stim [0:4*N_INST-1];           // word, write flag, rd, data per instruction
    logic [15:0] lfsr;
    int          cyc = 0;                       // rising edges since time zero
    int          err_cnt;
    int          test_err;
    int          test_cnt;
    int          exp_due[$];                    // cycle at which the write must show
    int          exp_num[$];
    logic [4:0]  exp_addr[$];
    logic [31:0] exp_data[$];

    rv32_core #(.PC_RESET(PC_START)) u_dut (.*);

    bind rv32_core rv32_core_chk u_chk (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_ack_inst (i_ack_inst),
        .o_stb_inst (o_stb_inst),
        .o_rd_wr    (o_rd_wr),
        .o_iaddr    (o_iaddr),
        .o_rd_addr  (o_rd_addr)
    );

    always #4 i_clk = ~i_clk;                   // 8 ns period

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the program did not complete", cyc);
            $display("Testbench failed");
            $finish;
        end
    end

    // 16-bit Fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    task automatic count_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic report_test(input string name);
        test_cnt++;
        $display("test %0d %s: %0d errors", test_cnt, name, test_err);
        test_err = 0;
    endtask

    // called once per falling edge, outputs are stable here
    task automatic check_retire();
        logic due_now;
        due_now = (exp_due.size() != 0) && (exp_due[0] == cyc);
        if (o_rd_wr) begin
            assert (due_now) else begin
                $display("unexpected register write to x%0d at cycle %0d", o_rd_addr, cyc);
                count_error();
            end
            if (due_now) begin
                assert (o_rd_addr == exp_addr[0]) else begin
                    $display("[FAIL] inst %0d o_rd_addr: got 0x%h, expected 0x%h",
                             exp_num[0], o_rd_addr, exp_addr[0]);
                    count_error();
                end
                assert (o_rd_data == exp_data[0]) else begin
                    $display("[FAIL] inst %0d o_rd_data: got 0x%h, expected 0x%h",
                             exp_num[0], o_rd_data, exp_data[0]);
                    count_error();
                end
            end
        end else begin
            assert (!due_now) else begin
                $display("instruction %0d did not write its register at cycle %0d",
                         exp_num[0], cyc);
                count_error();
            end
        end
        if (due_now) begin
            void'(exp_due.pop_front());
            void'(exp_num.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
    endtask

    // entered at time zero or on a falling edge
    task automatic apply_reset();
        i_arst_n   = 1'b0;
        i_ack_inst = 1'b0;
        repeat (2) begin
            @(negedge i_clk);
            assert (!o_rd_wr && !o_stb_inst) else begin
                $display("strobe or retire write active during reset");
                count_error();
            end
        end
        i_arst_n = 1'b1;                        // released on a falling edge
        @(negedge i_clk);
        assert (o_iaddr == PC_START) else begin
            $display("[FAIL] o_iaddr: got 0x%h, expected 0x%h", o_iaddr, PC_START);
            count_error();
        end
        assert (o_stb_inst && !o_rd_wr) else begin
            $display("fetch strobe not raised on the first edge after reset");
            count_error();
        end
    endtask

    task automatic run_program(input logic gaps);
        int   idx;
        logic b0;
        logic b1;
        logic gap;
        idx = 0;
        while (idx < N_INST) begin
            check_retire();
            gap = 1'b0;
            if (gaps) begin
                take_bit(b0);
                take_bit(b1);
                gap = b0 & b1;                  // one cycle in four without ack
            end
            assert (o_iaddr == PC_START + 4 * idx) else begin
                $display("[FAIL] o_iaddr: got 0x%h, expected 0x%h", o_iaddr,
                         PC_START + 4 * idx);
                count_error();
            end
            i_ack_inst = !gap;
            i_inst     = stim[4*idx];
            if (!gap && o_stb_inst) begin       // taken on the next rising edge
                if (stim[4*idx+1][0]) begin
                    exp_due.push_back(cyc + 3);
                    exp_num.push_back(idx);
                    exp_addr.push_back(stim[4*idx+2][4:0]);
                    exp_data.push_back(stim[4*idx+3]);
                end
                idx++;
            end
            @(negedge i_clk);
        end
        i_ack_inst = 1'b0;
        repeat (6) begin                        // let the pipe drain
            check_retire();
            @(negedge i_clk);
        end
        assert (exp_due.size() == 0) else begin
            $display("%0d expected writes never retired", exp_due.size());
            count_error();
        end
    endtask

    initial begin
        i_arst_n   = 1'b0;
        i_inst     = '0;
        i_ack_inst = 1'b0;
        lfsr       = LFSR_SEED;
        err_cnt    = 0;
        test_err   = 0;
        test_cnt   = 0;
        $readmemh("verification/rv32_stim.mem", stim);
        apply_reset();
        report_test("reset and first fetch");
        run_program(1'b0);
        report_test("program, ack every cycle");
        apply_reset();
        report_test("reset between runs");
        run_program(1'b1);
        report_test("program, random ack gaps");
        $display("done: %0d tests, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verification/rv32_stim.mem ====
// columns: instruction word, expected write flag, expected rd, expected rd data
// addresses run from 0x100 in steps of 4, one line per instruction
123450B7 1 01 12345000
FFB00113 1 02 FFFFFFFB
67808193 1 03 12345678
00218233 1 04 12345673
401202B3 1 05 00000673
00512333 1 06 00000001
005133B3 1 07 00000000
0030C433 1 08 00000678
005464B3 1 09 0000067B
0091F533 1 0A 00000678
006095B3 1 0B 2468A000
00615633 1 0C 7FFFFFFD
406156B3 1 0D FFFFFFFD
FFC12713 1 0E 00000001
00513793 1 0F 00000000
FFF1C813 1 10 EDCBA987
7FF06893 1 11 000007FF
0F087913 1 12 00000080
00489993 1 13 00007FF0
00885A13 1 14 00EDCBA9
40885A93 1 15 FFEDCBA9
00001B17 1 16 00001154
00508013 0 00 00000000
00112023 0 00 00000000
00000063 0 00 00000000
001B0BB3 1 17 12346154
001B8C13 1 18 12346155
417C0CB3 1 19 00000001

// ==== project.f ====
design/rv32_pkg.sv
design/rv32_pipe_if.sv
design/rv32_decode.sv
design/rv32_execute.sv
design/rv32_result.sv
design/rv32_core.sv
verification/rv32_core_chk.sv
verification/rv32_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv32_core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Testbench failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
